/* exec_alu.sv */
`include "exec_settings.svh"

module exec_alu import exec_pkg::*; (
  input  alu_op_t          alu_op,
  input  logic [`XLEN-1:0] operand_a,
  input  logic [`XLEN-1:0] operand_b,
  output logic [`XLEN-1:0] alu_result
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = operand_b[4:0]; // rv32 shifts use the low five bits only
  assign eq    = operand_a == operand_b;
  assign lt_s  = $signed(operand_a) < $signed(operand_b);
  assign lt_u  = operand_a < operand_b;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    alu_result = '0;
    case (alu_op)
      ADD:    alu_result = operand_a + operand_b;
      SUB:    alu_result = operand_a - operand_b;
      SLL:    alu_result = operand_a << shamt;
      SRL:    alu_result = operand_a >> shamt;
      SRA:    alu_result = $unsigned($signed(operand_a) >>> shamt);
      XOR:    alu_result = operand_a ^ operand_b;
      OR:     alu_result = operand_a | operand_b;
      AND:    alu_result = operand_a & operand_b;
      SLT:    alu_result[0] = lt_s;
      SLTU:   alu_result[0] = lt_u;
      EQ:     alu_result[0] = eq;
      NE:     alu_result[0] = ~eq;
      LT:     alu_result[0] = lt_s;
      GE:     alu_result[0] = ~lt_s;
      LTU:    alu_result[0] = lt_u;
      GEU:    alu_result[0] = ~lt_u;
      PASS_B: alu_result = operand_b;              // lui, and csrrw with the csr as b
      CLR_B:  alu_result = operand_b & ~operand_a; // csrrc clears the rs1 mask bits
      SET_B:  alu_result = operand_b | operand_a;  // csrrs
      default: alu_result = '0;                    // opcodes decode never emits
    endcase
  end

endmodule

/* exec_control.sv */
module exec_control (
  input  logic clock,
  input  logic reset,
  input  logic block,
  input  logic decode_valid,
  input  logic exception,
  input  logic fence_i,
  input  logic redirect,
  output logic advance,
  output logic npc_valid,
  output logic clear_cache,
  output logic clear_pipeline
);

  logic accept;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage advance and flush
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign advance = ~block; // a blocked stage holds every register

  // a taken redirect or a cache flush kills whatever decode offers this cycle
  assign clear_pipeline = (npc_valid & redirect) | clear_cache;

  assign accept = decode_valid & ~exception & ~clear_pipeline;

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid   <= 1'b0;
      clear_cache <= 1'b0;
    end else if (advance) begin
      npc_valid   <= accept;
      clear_cache <= accept & fence_i; // fence.i flushes the icache once
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the flush only ever belongs to a live instruction
  cache_clear_valid: assert property (
    @(posedge clock) disable iff (reset)
    clear_cache |-> npc_valid
  );

  // the flush clears the pipeline, so the next capture cannot repeat it
  cache_clear_single: assert property (
    @(posedge clock) disable iff (reset)
    (advance && clear_cache) |=> !clear_cache
  );

endmodule

/* exec_pkg.sv */
`include "exec_settings.svh"

package exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // selector encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [`ALU_OP_W-1:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    EQ, NE, LT, GE, LTU, GEU, // branch compares leave the outcome in bit 0
    PASS_B, CLR_B, SET_B      // lui and csr read-modify-write
  } alu_op_t;

  typedef enum logic [1:0] {OP1_SRC1, OP1_SELF, OP1_FWD} op1_sel_t;

  typedef enum logic [1:0] {RS2_NONE, RS2_SELF, RS2_FWD} rs2_fwd_t;

  typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_CSR} op2_sel_t;

  typedef enum logic [1:0] {CSR_IN, CSR_ALU, CSR_PREV} csr_sel_t;

  typedef enum logic [2:0] {
    NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH, NPC_CSR // csr covers ecall and mret
  } npc_sel_t;

  typedef enum logic [1:0] {WB_ALU, WB_SNPC, WB_DNPC, WB_CSR} wb_sel_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode to execute and execute to memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] csr_src; // value read from the csr file
    alu_op_t          alu_op;
    op1_sel_t         op1_sel;
    rs2_fwd_t         rs2_fwd;
    op2_sel_t         op2_sel;
    csr_sel_t         csr_sel;
    npc_sel_t         npc_sel;
    wb_sel_t          wb_sel;
    logic             fence_i;
  } exec_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] snpc;
    logic [`XLEN-1:0] wb_data;    // integer register writeback
    logic [`XLEN-1:0] csr_wdata;
    logic [`XLEN-1:0] store_data;
  } exec_res_t;

endpackage

/* exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN 32 // data and address width

`define ALU_OP_W 8 // alu opcode field as it comes from decode

`define PC_STEP 32'd4 // sequential fetch step, no compressed instructions

`endif

/* exec_stage.sv */
`include "exec_settings.svh"

module exec_stage import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             block,
  input  logic             decode_valid,
  input  logic             exception,
  input  exec_req_t        req,
  input  logic [`XLEN-1:0] forward_data,
  output exec_res_t        res,
  output logic             npc_valid,
  output logic             clear_pipeline,
  output logic             clear_cache
);

  logic             advance;
  logic             redirect;
  alu_op_t          alu_op_q;
  logic [`XLEN-1:0] operand_a;
  logic [`XLEN-1:0] operand_b;
  logic [`XLEN-1:0] csr_src_q;
  logic [`XLEN-1:0] store_data;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] snpc;
  logic [`XLEN-1:0] npc;
  logic [`XLEN-1:0] wb_data;
  logic [`XLEN-1:0] csr_wdata;

  exec_control u_control (
    .clock, .reset, .block, .decode_valid, .exception,
    .fence_i (req.fence_i),
    .redirect, .advance, .npc_valid, .clear_cache, .clear_pipeline
  );

  operand_select u_operands (
    .clock, .advance, .req, .forward_data, .wb_data, .alu_result, .csr_wdata,
    .alu_op_q, .operand_a, .operand_b, .csr_src_q, .store_data
  );

  exec_alu u_alu (.alu_op (alu_op_q), .operand_a, .operand_b, .alu_result);

  next_pc_unit u_next_pc (
    .clock, .advance, .req, .alu_result, .csr_src_q,
    .pc_q, .snpc, .npc, .wb_data, .csr_wdata, .redirect
  );

  assign res = '{pc: pc_q, alu_result: alu_result, npc: npc, snpc: snpc,
                 wb_data: wb_data, csr_wdata: csr_wdata, store_data: store_data};

endmodule

/* exec_stage_tb.sv */
`include "exec_settings.svh"

module exec_stage_tb import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLOCK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 4000;

  logic             clock = 1'b0;
  logic             reset;
  logic             block;
  logic             decode_valid;
  logic             exception;
  exec_req_t        req;
  logic [`XLEN-1:0] forward_data;
  exec_res_t        res;
  logic             npc_valid;
  logic             clear_pipeline;
  logic             clear_cache;

  exec_res_t        exp_res;   // reference copy of every result field
  logic [`XLEN-1:0] exp_dnpc;
  logic [`XLEN-1:0] exp_csr_src;
  npc_sel_t         exp_npc_sel;
  logic             exp_valid;
  logic             exp_cc;
  logic             checking;
  int               error_count;
  int               hold_left; // remaining cycles of the current block stretch

  exec_stage uut (.*);

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [`XLEN-1:0] alu_model(alu_op_t op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    logic [`XLEN:0]     diff;
    logic [2*`XLEN-1:0] ext;
    logic               below_u;
    logic               below_s;
    diff    = {1'b0, a} - {1'b0, b};
    ext     = {{`XLEN{a[`XLEN-1]}}, a} >> b[4:0];
    below_u = diff[`XLEN]; // borrow out of the wide subtract
    below_s = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN];
    case (op)
      ADD:       return a + b;
      SUB:       return diff[`XLEN-1:0];
      SLL:       return a << b[4:0];
      SRL:       return a >> b[4:0];
      SRA:       return ext[`XLEN-1:0];
      XOR:       return a ^ b;
      OR:        return a | b;
      AND:       return a & b;
      SLT, LT:   return `XLEN'(below_s);
      SLTU, LTU: return `XLEN'(below_u);
      GE:        return `XLEN'(!below_s);
      GEU:       return `XLEN'(!below_u);
      EQ:        return `XLEN'(diff[`XLEN-1:0] == '0);
      NE:        return `XLEN'(diff[`XLEN-1:0] != '0);
      PASS_B:    return b;
      CLR_B:     return b & ~a;
      SET_B:     return b | a;
      default:   return '0;
    endcase
  endfunction

  task automatic model_capture();
    logic [`XLEN-1:0] s1;
    logic [`XLEN-1:0] s2;
    logic [`XLEN-1:0] csr;
    logic             accept;
    s1 = (req.op1_sel == OP1_SELF) ? exp_res.wb_data :
         (req.op1_sel == OP1_FWD) ? forward_data : req.src1;
    s2 = (req.rs2_fwd == RS2_SELF) ? exp_res.wb_data :
         (req.rs2_fwd == RS2_FWD) ? forward_data : req.src2;
    csr = (req.csr_sel == CSR_ALU) ? exp_res.alu_result :
          (req.csr_sel == CSR_PREV) ? exp_res.csr_wdata : req.csr_src;
    accept = decode_valid && !exception &&
             !((exp_valid && exp_npc_sel != NPC_SEQ) || exp_cc); // clear of the old state
    exp_valid = !reset && accept;
    exp_cc    = !reset && accept && req.fence_i;
    exp_res.csr_wdata  = exp_res.alu_result;
    exp_res.pc         = req.pc;
    exp_res.snpc       = req.pc + `PC_STEP;
    exp_res.store_data = s2;
    exp_dnpc           = req.pc + req.imm;
    exp_csr_src        = csr;
    exp_npc_sel        = req.npc_sel;
    exp_res.alu_result = alu_model(req.alu_op, s1, (req.op2_sel == OP2_IMM) ? req.imm :
                                   (req.op2_sel == OP2_CSR) ? csr : s2);
    case (req.npc_sel)
      NPC_JAL:    exp_res.npc = exp_dnpc;
      NPC_JALR:   exp_res.npc = exp_res.alu_result & ~`XLEN'(1);
      NPC_BRANCH: exp_res.npc = exp_res.alu_result[0] ? exp_dnpc : exp_res.snpc;
      NPC_CSR:    exp_res.npc = exp_csr_src;
      default:    exp_res.npc = exp_res.snpc;
    endcase
    exp_res.wb_data = (req.wb_sel == WB_SNPC) ? exp_res.snpc :
                      (req.wb_sel == WB_DNPC) ? exp_dnpc :
                      (req.wb_sel == WB_CSR) ? exp_csr_src : exp_res.alu_result;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // in reset every source comes from the inputs so the model starts from known values
  task automatic drive_random(input logic safe);
    req.pc       = $urandom();
    req.imm      = $urandom();
    req.src1     = $urandom();
    req.src2     = $urandom();
    req.csr_src  = $urandom();
    req.alu_op   = alu_op_t'($urandom_range(0, SET_B));
    req.op1_sel  = safe ? OP1_SRC1 : op1_sel_t'($urandom_range(0, OP1_FWD));
    req.rs2_fwd  = safe ? RS2_NONE : rs2_fwd_t'($urandom_range(0, RS2_FWD));
    req.op2_sel  = op2_sel_t'($urandom_range(0, OP2_CSR));
    req.csr_sel  = safe ? CSR_IN : csr_sel_t'($urandom_range(0, CSR_PREV));
    req.npc_sel  = npc_sel_t'($urandom_range(0, NPC_CSR));
    req.wb_sel   = wb_sel_t'($urandom_range(0, WB_CSR));
    req.fence_i  = $urandom_range(0, 7) == 0;
    forward_data = $urandom();
    decode_valid = $urandom_range(0, 7) != 0;
    exception    = $urandom_range(0, 15) == 0;
    if (safe) begin
      block = 1'b0;
    end else if (hold_left > 0) begin
      block = 1'b1;
      hold_left--;
    end else if ($urandom_range(0, 9) == 0) begin
      block     = 1'b1;
      hold_left = $urandom_range(0, 4); // stretches of one to five cycles
    end else begin
      block = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(32'h5af8_d62d));
    reset        = 1'b1;
    block        = 1'b0;
    decode_valid = 1'b0;
    exception    = 1'b0;
    req          = '0;
    forward_data = '0;
    checking     = 1'b0;
    error_count  = 0;
    hold_left    = 0;
    for (int cyc = 0; cyc < RESET_CYCLES + TEST_CYCLES; cyc++) begin
      @(posedge clock);
      #1;
      if (!block) model_capture();
      checking = cyc >= RESET_CYCLES;
      #1;
      reset = cyc < RESET_CYCLES - 1;
      drive_random(cyc < RESET_CYCLES);
    end
    @(posedge clock);
    #1;
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + TEST_CYCLES + 100) * CLOCK_PERIOD);
    $display("timeout: the stimulus loop did not finish in the expected time");
    $display("STATUS: FAIL");
    $fatal(1);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic value_error(input string name, input logic [`XLEN-1:0] expected,
                             input logic [`XLEN-1:0] actual);
    error_count++;
    $display("** Error: %s expected %h actual %h", name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_failed(input string what);
    error_count++;
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  property holds(ok);
    @(posedge clock) disable iff (!checking) ok;
  endproperty

  pc_match: assert property (holds(res.pc == exp_res.pc))
    else value_error("res.pc", $sampled(exp_res.pc), $sampled(res.pc));
  alu_match: assert property (holds(res.alu_result == exp_res.alu_result))
    else value_error("res.alu_result", $sampled(exp_res.alu_result), $sampled(res.alu_result));
  npc_match: assert property (holds(res.npc == exp_res.npc))
    else value_error("res.npc", $sampled(exp_res.npc), $sampled(res.npc));
  snpc_match: assert property (holds(res.snpc == exp_res.snpc))
    else value_error("res.snpc", $sampled(exp_res.snpc), $sampled(res.snpc));
  wb_match: assert property (holds(res.wb_data == exp_res.wb_data))
    else value_error("res.wb_data", $sampled(exp_res.wb_data), $sampled(res.wb_data));
  csr_match: assert property (holds(res.csr_wdata == exp_res.csr_wdata))
    else value_error("res.csr_wdata", $sampled(exp_res.csr_wdata), $sampled(res.csr_wdata));
  store_match: assert property (holds(res.store_data == exp_res.store_data))
    else value_error("res.store_data", $sampled(exp_res.store_data), $sampled(res.store_data));
  valid_match: assert property (holds(npc_valid == exp_valid))
    else value_error("npc_valid", $sampled(exp_valid), $sampled(npc_valid));
  cache_match: assert property (holds(clear_cache == exp_cc))
    else value_error("clear_cache", $sampled(exp_cc), $sampled(clear_cache));
  clear_match: assert property (holds(clear_pipeline ==
                                      ((exp_valid && exp_npc_sel != NPC_SEQ) || exp_cc)))
    else value_error("clear_pipeline", $sampled((exp_valid && exp_npc_sel != NPC_SEQ) || exp_cc),
                     $sampled(clear_pipeline));

  hold_while_blocked: assert property (@(posedge clock) disable iff (!checking)
    block |=> $stable(res) && $stable(npc_valid) && $stable(clear_cache))
    else check_failed("outputs changed while block was high");

endmodule

/* next_pc_unit.sv */
`include "exec_settings.svh"

module next_pc_unit import exec_pkg::*; (
  input  logic             clock,
  input  logic             advance,
  input  exec_req_t        req,
  input  logic [`XLEN-1:0] alu_result,
  input  logic [`XLEN-1:0] csr_src_q,
  output logic [`XLEN-1:0] pc_q,
  output logic [`XLEN-1:0] snpc,
  output logic [`XLEN-1:0] npc,
  output logic [`XLEN-1:0] wb_data,
  output logic [`XLEN-1:0] csr_wdata,
  output logic             redirect
);

  logic [`XLEN-1:0] dnpc;
  npc_sel_t         npc_sel_q;
  wb_sel_t          wb_sel_q;

  always_ff @(posedge clock) begin
    if (advance) begin
      pc_q      <= req.pc;
      snpc      <= req.pc + `PC_STEP;
      dnpc      <= req.pc + req.imm; // jal and branch target, also auipc
      npc_sel_q <= req.npc_sel;
      wb_sel_q  <= req.wb_sel;
      csr_wdata <= alu_result; // alu result of the instruction now leaving
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc and writeback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (npc_sel_q)
      NPC_SEQ:    npc = snpc;
      NPC_JAL:    npc = dnpc;
      NPC_JALR:   npc = {alu_result[`XLEN-1:1], 1'b0};
      NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc; // compare outcome sits in bit 0
      NPC_CSR:    npc = csr_src_q;                   // mtvec on ecall, mepc on mret
      default:    npc = '0;
    endcase
  end

  always_comb begin
    case (wb_sel_q)
      WB_SNPC: wb_data = snpc;      // link address
      WB_DNPC: wb_data = dnpc;
      WB_CSR:  wb_data = csr_src_q; // old csr value goes to rd
      default: wb_data = alu_result;
    endcase
  end

  assign redirect = npc_sel_q != NPC_SEQ;

  jalr_target_aligned: assert property (
    @(posedge clock) (npc_sel_q == NPC_JALR) |-> (npc[0] == 1'b0)
  );

endmodule

/* operand_select.sv */
`include "exec_settings.svh"

module operand_select import exec_pkg::*; (
  input  logic             clock,
  input  logic             advance,
  input  exec_req_t        req,
  input  logic [`XLEN-1:0] forward_data, // result from a later stage
  input  logic [`XLEN-1:0] wb_data,      // this stage's own last result
  input  logic [`XLEN-1:0] alu_result,
  input  logic [`XLEN-1:0] csr_wdata,
  output alu_op_t          alu_op_q,
  output logic [`XLEN-1:0] operand_a,
  output logic [`XLEN-1:0] operand_b,
  output logic [`XLEN-1:0] csr_src_q,
  output logic [`XLEN-1:0] store_data
);

  logic [`XLEN-1:0] src1_fwd;
  logic [`XLEN-1:0] src2_fwd;
  logic [`XLEN-1:0] csr_fwd;
  logic [`XLEN-1:0] op2_mux;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (req.op1_sel)
      OP1_SELF: src1_fwd = wb_data;
      OP1_FWD:  src1_fwd = forward_data;
      default:  src1_fwd = req.src1;
    endcase
  end

  always_comb begin
    case (req.rs2_fwd)
      RS2_SELF: src2_fwd = wb_data;
      RS2_FWD:  src2_fwd = forward_data;
      default:  src2_fwd = req.src2;
    endcase
  end

  always_comb begin
    case (req.csr_sel)
      CSR_ALU:  csr_fwd = alu_result; // csr written by the instruction just ahead
      CSR_PREV: csr_fwd = csr_wdata;
      default:  csr_fwd = req.csr_src;
    endcase
  end

  always_comb begin
    case (req.op2_sel)
      OP2_IMM: op2_mux = req.imm;
      OP2_CSR: op2_mux = csr_fwd;
      default: op2_mux = src2_fwd;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (advance) begin
      alu_op_q   <= req.alu_op;
      operand_a  <= src1_fwd;
      operand_b  <= op2_mux;
      csr_src_q  <= csr_fwd;
      store_data <= src2_fwd; // stores need rs2 even when operand 2 is the offset
    end
  end

  op2_sel_legal: assert property (
    @(posedge clock) advance |-> req.op2_sel inside {OP2_RS2, OP2_IMM, OP2_CSR}
  );

endmodule

/* sources.f */
+incdir+.
exec_pkg.sv
exec_control.sv
operand_select.sv
exec_alu.sv
next_pc_unit.sv
exec_stage.sv
exec_stage_tb.sv
